// File: source/uart_pkg.sv
package uart_pkg;

	// frame timing seen by both framer and receiver
	localparam int SAMPLES_PER_BIT = 8; // oversample strobes in one bit period
	localparam int SYNC_STAGES = 3; // flops on the rx line before any logic

	localparam int MAX_DATA_WIDTH = 8; // widest word carried in rx_result_t

	// receiver FSM, one state per frame field
	typedef enum logic [2:0] {
		IDLE   = 3'd0, // line high, watching for a falling edge
		START  = 3'd1, // edge seen, waiting for mid start bit
		DATA   = 3'd2, // shifting data bits in, lsb first
		PARITY = 3'd3, // parity bit sample
		STOP   = 3'd4 // stop bit sample, word reported here
	} rx_state_e;

	// word handed to the user with its error flags
	typedef struct packed {
		logic [MAX_DATA_WIDTH-1:0] data; // upper bits zero when DATA_WIDTH < 8
		logic parity_err; // parity bit disagrees with data
		logic framing_err; // stop bit sampled low
	} rx_result_t;

endpackage

// File: source/uart_baud_gen.sv
`timescale 1ns/100ps

module uart_baud_gen #(
	parameter int CLKS_PER_SAMPLE = 2
) (
	input  logic i_tx_clk,
	input  logic i_reset_tx,
	output logic o_sample_stb,
	output logic o_bit_tick
);
	localparam int CNT_W = $clog2(CLKS_PER_SAMPLE);
	localparam int STB_W = $clog2(uart_pkg::SAMPLES_PER_BIT);

	logic [CNT_W-1:0] clk_cnt; // tx_clk cycles inside one sample period
	logic [STB_W-1:0] stb_cnt; // strobes inside one bit period
	logic clk_wrap;
	logic stb_wrap;

	assign clk_wrap = (clk_cnt == CNT_W'(CLKS_PER_SAMPLE - 1));
	assign stb_wrap = (stb_cnt == STB_W'(uart_pkg::SAMPLES_PER_BIT - 1));

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			clk_cnt <= '0;
			stb_cnt <= '0;
			o_sample_stb <= 1'b0;
			o_bit_tick <= 1'b0;
		end else begin
			o_sample_stb <= clk_wrap; // one cycle every CLKS_PER_SAMPLE
			o_bit_tick <= clk_wrap && stb_wrap; // eighth strobe marks the bit edge
			if (clk_wrap) begin
				clk_cnt <= '0;
				stb_cnt <= stb_wrap ? '0 : stb_cnt + 1'b1;
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// framer and receiver both rely on ticks lining up with a strobe
	a_tick_on_stb: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		o_bit_tick |-> o_sample_stb);

endmodule

// File: source/uart_tx_fifo.sv
`timescale 1ns/100ps

module uart_tx_fifo #(
	parameter int DATA_WIDTH = 8,
	parameter int FIFO_DEPTH = 4
) (
	input  logic i_tx_clk,
	input  logic i_reset_tx,
	input  logic i_push,
	input  logic [DATA_WIDTH-1:0] i_data,
	input  logic i_pop,
	output logic [DATA_WIDTH-1:0] o_head,
	output logic o_empty,
	output logic o_credit
);
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH]; // word storage
	logic [PTR_W-1:0] wr_ptr; // next free slot
	logic [PTR_W-1:0] rd_ptr; // oldest word
	logic [PTR_W:0] count; // occupancy, one extra bit to hold FIFO_DEPTH

	always_ff @(posedge i_tx_clk) begin
		if (i_push)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps itself
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({i_push, i_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // push and pop together leave it unchanged
			endcase
		end
	end

	assign o_head = mem[rd_ptr]; // head is visible the cycle after the push
	assign o_empty = (count == '0);
	assign o_credit = i_pop; // a slot frees as the framer takes the head

	// user side must hold a credit, a pop in the same cycle frees one
	a_no_push_full: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		i_push |-> (count != (PTR_W + 1)'(FIFO_DEPTH)) || i_pop);

	// framer pops only on a non-empty queue
	a_no_pop_empty: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		i_pop |-> !o_empty);

endmodule

// File: source/uart_tx_framer.sv
`timescale 1ns/100ps

module uart_tx_framer #(
	parameter int DATA_WIDTH = 8,
	parameter int PARITY_ODD = 0
) (
	input  logic i_tx_clk,
	input  logic i_reset_tx,
	input  logic i_bit_tick,
	input  logic i_empty,
	input  logic [DATA_WIDTH-1:0] i_head,
	output logic o_pop,
	output logic o_serial,
	output logic o_busy
);
	localparam int FRAME_BITS = DATA_WIDTH + 3; // start, data, parity, stop
	localparam int CNT_W = $clog2(FRAME_BITS);

	logic [DATA_WIDTH+1:0] shift_q; // stop, parity and data bits still to send
	logic [CNT_W-1:0] bit_cnt; // which frame bit is on the line now
	logic busy_q;
	logic last_bit; // stop bit on the line
	logic parity_bit;

	assign last_bit = busy_q && (bit_cnt == CNT_W'(FRAME_BITS - 1));
	assign parity_bit = (^i_head) ^ (PARITY_ODD != 0); // odd parity inverts the xor

	// a new frame starts on an idle tick or straight after a stop bit
	assign o_pop = i_bit_tick && !i_empty && (!busy_q || last_bit);
	assign o_busy = busy_q;

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			busy_q <= 1'b0;
			bit_cnt <= '0;
			o_serial <= 1'b1; // line idles high
		end else if (o_pop) begin
			busy_q <= 1'b1;
			bit_cnt <= '0;
			o_serial <= 1'b0; // start bit
		end else if (i_bit_tick && last_bit) begin
			busy_q <= 1'b0; // stop bit done, queue empty
			o_serial <= 1'b1;
		end else if (i_bit_tick && busy_q) begin
			bit_cnt <= bit_cnt + 1'b1;
			o_serial <= shift_q[0]; // lsb first
		end
	end

	// frame contents held apart from the control state
	always_ff @(posedge i_tx_clk) begin
		if (o_pop)
			shift_q <= {1'b1, parity_bit, i_head};
		else if (i_bit_tick && busy_q)
			shift_q <= {1'b1, shift_q[DATA_WIDTH+1:1]}; // fill with idle level
	end

	// line must rest at mark between frames
	a_idle_high: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		!o_busy |-> o_serial);

endmodule

// File: source/uart_rx_deframer.sv
`timescale 1ns/100ps

module uart_rx_deframer #(
	parameter int DATA_WIDTH = 8,
	parameter int PARITY_ODD = 0
) (
	input  logic i_tx_clk,
	input  logic i_reset_tx,
	input  logic i_sample_stb,
	input  logic i_serial,
	output logic o_rx_valid,
	output uart_pkg::rx_result_t o_rx
);
	localparam int SMP_W = $clog2(uart_pkg::SAMPLES_PER_BIT);
	localparam int IDX_W = $clog2(DATA_WIDTH);
	localparam int HALF_BIT = uart_pkg::SAMPLES_PER_BIT / 2;

	logic [uart_pkg::SYNC_STAGES-1:0] sync_q; // line synchronizer chain
	logic rx_bit; // synchronized line level
	logic line_prev; // level at the previous strobe
	uart_pkg::rx_state_e state;
	logic [SMP_W-1:0] smp_cnt; // strobes since the last mid-bit point
	logic [IDX_W-1:0] bit_idx; // data bit being taken
	logic [DATA_WIDTH-1:0] data_sr; // data shifts in from the top
	logic par_bit; // sampled parity bit
	logic mid_bit; // strobe at the middle of a bit
	uart_pkg::rx_result_t result;

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx)
			sync_q <= '1; // start from a high line, no spurious edge
		else
			sync_q <= {sync_q[uart_pkg::SYNC_STAGES-2:0], i_serial};
	end

	assign rx_bit = sync_q[uart_pkg::SYNC_STAGES-1];
	assign mid_bit = i_sample_stb && (smp_cnt == SMP_W'(uart_pkg::SAMPLES_PER_BIT - 1));

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			state <= uart_pkg::IDLE;
			line_prev <= 1'b1;
			smp_cnt <= '0;
			bit_idx <= '0;
			o_rx_valid <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0; // single cycle pulse
			if (i_sample_stb) begin
				line_prev <= rx_bit;
				smp_cnt <= smp_cnt + 1'b1; // wraps once per bit period
			end
			case (state)
				uart_pkg::IDLE: begin
					if (i_sample_stb && line_prev && !rx_bit) begin
						state <= uart_pkg::START; // falling edge, maybe a start bit
						smp_cnt <= '0;
					end
				end
				uart_pkg::START: begin
					if (i_sample_stb && (smp_cnt == SMP_W'(HALF_BIT - 1))) begin
						smp_cnt <= '0; // realign so later samples land mid-bit
						bit_idx <= '0;
						if (rx_bit)
							state <= uart_pkg::IDLE; // glitch, not a start bit
						else
							state <= uart_pkg::DATA;
					end
				end
				uart_pkg::DATA: begin
					if (mid_bit) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_W'(DATA_WIDTH - 1))
							state <= uart_pkg::PARITY;
					end
				end
				uart_pkg::PARITY: begin
					if (mid_bit)
						state <= uart_pkg::STOP;
				end
				uart_pkg::STOP: begin
					if (mid_bit) begin
						state <= uart_pkg::IDLE;
						o_rx_valid <= 1'b1; // report at mid stop bit
					end
				end
				default: state <= uart_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge i_tx_clk) begin
		if (mid_bit && (state == uart_pkg::DATA))
			data_sr <= {rx_bit, data_sr[DATA_WIDTH-1:1]}; // lsb arrives first
		if (mid_bit && (state == uart_pkg::PARITY))
			par_bit <= rx_bit;
		if (mid_bit && (state == uart_pkg::STOP))
			o_rx <= result;
	end

	always_comb begin
		result = '0; // clears unused upper data bits
		result.data[DATA_WIDTH-1:0] = data_sr;
		result.parity_err = (^data_sr) ^ par_bit ^ (PARITY_ODD != 0);
		result.framing_err = !rx_bit; // stop bit seen low
	end

	a_valid_pulse: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		o_rx_valid |=> !o_rx_valid);

	// 3-bit state has three unused codes
	a_state_legal: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		state inside {uart_pkg::IDLE, uart_pkg::START, uart_pkg::DATA,
			uart_pkg::PARITY, uart_pkg::STOP});

endmodule

// File: source/uart_top.sv
`timescale 1ns/100ps

module uart_top #(
	parameter int DATA_WIDTH = 8, // 5 to 8
	parameter int PARITY_ODD = 0, // 0 even, 1 odd
	parameter int CLKS_PER_SAMPLE = 2, // at least 2
	parameter int FIFO_DEPTH = 4 // power of two
) (
	input  logic i_tx_clk,
	input  logic i_reset_tx,
	input  logic i_push,
	input  logic [DATA_WIDTH-1:0] i_data,
	output logic o_credit,
	output logic o_tx_busy,
	output logic o_serial_out,
	input  logic i_serial_in,
	output logic o_rx_valid,
	output uart_pkg::rx_result_t o_rx
);
	logic sample_stb; // oversample strobe for the receiver
	logic bit_tick; // bit edge for the framer
	logic fifo_empty;
	logic fifo_pop;
	logic [DATA_WIDTH-1:0] fifo_head;

	uart_baud_gen #(
		.CLKS_PER_SAMPLE(CLKS_PER_SAMPLE)
	) u_baud_gen (
		.i_tx_clk(i_tx_clk),
		.i_reset_tx(i_reset_tx),
		.o_sample_stb(sample_stb),
		.o_bit_tick(bit_tick)
	);

	uart_tx_fifo #(
		.DATA_WIDTH(DATA_WIDTH),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_tx_fifo (
		.i_tx_clk(i_tx_clk),
		.i_reset_tx(i_reset_tx),
		.i_push(i_push),
		.i_data(i_data),
		.i_pop(fifo_pop),
		.o_head(fifo_head),
		.o_empty(fifo_empty),
		.o_credit(o_credit)
	);

	uart_tx_framer #(
		.DATA_WIDTH(DATA_WIDTH),
		.PARITY_ODD(PARITY_ODD)
	) u_tx_framer (
		.i_tx_clk(i_tx_clk),
		.i_reset_tx(i_reset_tx),
		.i_bit_tick(bit_tick),
		.i_empty(fifo_empty),
		.i_head(fifo_head),
		.o_pop(fifo_pop),
		.o_serial(o_serial_out),
		.o_busy(o_tx_busy)
	);

	// serial input kept separate, loopback is wired outside
	uart_rx_deframer #(
		.DATA_WIDTH(DATA_WIDTH),
		.PARITY_ODD(PARITY_ODD)
	) u_rx_deframer (
		.i_tx_clk(i_tx_clk),
		.i_reset_tx(i_reset_tx),
		.i_sample_stb(sample_stb),
		.i_serial(i_serial_in),
		.o_rx_valid(o_rx_valid),
		.o_rx(o_rx)
	);

endmodule

// File: tb/tb_uart_top.sv
`timescale 1ns/100ps

module tb_uart_top;
	localparam int DATA_WIDTH = 8;
	localparam int PARITY_ODD = 0;
	localparam int CLKS_PER_SAMPLE = 2;
	localparam int FIFO_DEPTH = 4;
	localparam int BIT_CLKS = CLKS_PER_SAMPLE * 8; // one line bit in tx_clk cycles
	localparam int FRAME_CLKS = BIT_CLKS * (DATA_WIDTH + 3); // start, data, parity, stop
	localparam int NUM_WORDS = 200;
	localparam logic [31:0] SEED = 32'h9431;

	logic tx_clk;
	logic reset_tx;
	logic i_push;
	logic [DATA_WIDTH-1:0] i_data;
	logic o_credit;
	logic o_tx_busy;
	logic o_serial_out;
	logic serial_in; // line into the receiver
	logic o_rx_valid;
	uart_pkg::rx_result_t o_rx;

	logic use_loopback; // 1 wires tx back to rx, 0 hands the line to the bit-banger
	logic bang_line; // bit-banger output level
	int credits; // credits the user side holds
	uart_pkg::rx_result_t expected_q[$]; // reference model, oldest first

	assign serial_in = use_loopback ? o_serial_out : bang_line;

	uart_top #(
		.DATA_WIDTH(DATA_WIDTH),
		.PARITY_ODD(PARITY_ODD),
		.CLKS_PER_SAMPLE(CLKS_PER_SAMPLE),
		.FIFO_DEPTH(FIFO_DEPTH)
	) dut0 (
		.i_tx_clk(tx_clk),
		.i_reset_tx(reset_tx),
		.i_push(i_push),
		.i_data(i_data),
		.o_credit(o_credit),
		.o_tx_busy(o_tx_busy),
		.o_serial_out(o_serial_out),
		.i_serial_in(serial_in),
		.o_rx_valid(o_rx_valid),
		.o_rx(o_rx)
	);

	initial begin
		tx_clk = 1'b0;
		forever #5 tx_clk = ~tx_clk; // 10 ns period
	end

	// even parity is the xor of the data, odd inverts it
	function automatic logic parity_of(input logic [DATA_WIDTH-1:0] d);
		return (^d) ^ (PARITY_ODD != 0);
	endfunction

	function automatic uart_pkg::rx_result_t make_result(input logic [DATA_WIDTH-1:0] d,
		input logic perr, input logic ferr);
		uart_pkg::rx_result_t r;
		r = '0; // upper data bits stay zero
		r.data[DATA_WIDTH-1:0] = d;
		r.parity_err = perr;
		r.framing_err = ferr;
		return r;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] random_word();
		return DATA_WIDTH'($urandom_range(0, (1 << DATA_WIDTH) - 1));
	endfunction

	task automatic fail_run(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_rx();
		uart_pkg::rx_result_t exp;
		if (expected_q.size() == 0)
			fail_run("o_rx_valid pulsed while no word was outstanding");
		exp = expected_q.pop_front(); // words must arrive in push order
		check_equal("o_rx.data", 32'(o_rx.data), 32'(exp.data));
		check_equal("o_rx.parity_err", 32'(o_rx.parity_err), 32'(exp.parity_err));
		check_equal("o_rx.framing_err", 32'(o_rx.framing_err), 32'(exp.framing_err));
	endtask

	// one clock step, all sampling at the falling edge where outputs are settled
	task automatic next_cycle();
		@(negedge tx_clk);
		i_push = 1'b0; // push lasts a single cycle
		if (o_credit)
			credits++; // framer took a word
		if (credits > FIFO_DEPTH)
			fail_run("more credits came back than were spent");
		if (o_rx_valid)
			check_rx();
	endtask

	task automatic hold_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic push_word(input logic [DATA_WIDTH-1:0] d);
		i_push = 1'b1;
		i_data = d;
		credits--;
		expected_q.push_back(make_result(d, 1'b0, 1'b0)); // loopback words arrive clean
	endtask

	task automatic run_loopback();
		int pushed;
		int gap;
		int cycles;
		pushed = 0;
		gap = 0;
		cycles = 0;
		while (pushed < NUM_WORDS) begin
			if (cycles == NUM_WORDS * FRAME_CLKS * 3)
				fail_run("timeout pushing loopback words, credits stopped coming back");
			next_cycle();
			cycles++;
			if (gap > 0)
				gap--;
			else if (credits > 0) begin
				push_word(random_word());
				pushed++;
				// mostly short gaps so the queue fills, now and then a long idle
				gap = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 2 * FRAME_CLKS)
					: $urandom_range(0, 4);
			end
		end
	endtask

	task automatic wait_drained(input int limit, input string what);
		int n;
		n = 0;
		while ((expected_q.size() != 0) || o_tx_busy) begin
			if (n == limit)
				fail_run({"timeout waiting for ", what});
			next_cycle();
			n++;
		end
	endtask

	// frame built by hand, lsb first, each bit held one bit period
	task automatic send_frame(input logic [DATA_WIDTH-1:0] d, input logic flip_parity,
		input logic low_stop);
		logic [DATA_WIDTH+2:0] bits;
		bits = {!low_stop, parity_of(d) ^ flip_parity, d, 1'b0};
		expected_q.push_back(make_result(d, flip_parity, low_stop));
		for (int b = 0; b < DATA_WIDTH + 3; b++) begin
			bang_line = bits[b];
			hold_cycles(BIT_CLKS);
		end
		bang_line = 1'b1; // back to mark
	endtask

	initial begin
		int unsigned seed_ret;
		reset_tx = 1'b1;
		i_push = 1'b0;
		i_data = '0;
		use_loopback = 1'b1;
		bang_line = 1'b1;
		credits = FIFO_DEPTH;
		seed_ret = $urandom(SEED); // seeds this thread once

		repeat (8) @(negedge tx_clk);
		reset_tx = 1'b0;

		check_equal("o_serial_out", 32'(o_serial_out), 32'd1); // idle line after reset
		check_equal("o_tx_busy", 32'(o_tx_busy), 32'd0);
		check_equal("o_credit", 32'(o_credit), 32'd0);
		check_equal("o_rx_valid", 32'(o_rx_valid), 32'd0);

		run_loopback();
		wait_drained(4 * FIFO_DEPTH * FRAME_CLKS, "loopback words and o_tx_busy to clear");
		check_equal("credits", 32'(credits), 32'(FIFO_DEPTH)); // all credits home

		use_loopback = 1'b0; // tx is idle and high, safe to switch
		hold_cycles(BIT_CLKS);

		send_frame(random_word(), 1'b1, 1'b0); // parity bit inverted
		wait_drained(2 * FRAME_CLKS, "parity error frame");

		send_frame(random_word(), 1'b0, 1'b1); // stop bit low
		wait_drained(2 * FRAME_CLKS, "framing error frame");
		hold_cycles(2 * BIT_CLKS); // line rests high again
		send_frame(random_word(), 1'b0, 1'b0);
		wait_drained(2 * FRAME_CLKS, "clean frame after framing error");

		bang_line = 1'b0; // glitch, a quarter bit long
		hold_cycles(BIT_CLKS / 4);
		bang_line = 1'b1;
		hold_cycles(2 * FRAME_CLKS); // any o_rx_valid here fails in check_rx
		send_frame(random_word(), 1'b0, 1'b0);
		wait_drained(2 * FRAME_CLKS, "clean frame after false start");

		$display("sim passed");
		$finish;
	end

endmodule

// File: filelist.f
source/uart_pkg.sv
source/uart_baud_gen.sv
source/uart_tx_fifo.sv
source/uart_tx_framer.sv
source/uart_rx_deframer.sv
source/uart_top.sv
tb/tb_uart_top.sv

// File: Bender.yml
package:
  name: uart_loopback

sources:
  - source/uart_pkg.sv
  - source/uart_baud_gen.sv
  - source/uart_tx_fifo.sv
  - source/uart_tx_framer.sv
  - source/uart_rx_deframer.sv
  - source/uart_top.sv
  - target: simulation
    files:
      - tb/tb_uart_top.sv
